//--- source/fp_mac_pkg.sv
// fp_mac shared definitions
// widths, operand and result types, multiplier depth and MAC state encoding
// for the mantissa multiply-accumulate stage

package fp_mac_pkg;

    // mantissa and result widths
    localparam int MANT_W = 56;
    localparam int RES_W = 110;

    // the addend is lined up with the product's binary point
    localparam int ALIGN_SHIFT = 54;

    // default multiplier depth, legal range 1 to 3
    localparam int MUL_STAGES = 2;

    // completed operation counter
    localparam int CNT_W = 16;

    typedef logic signed [MANT_W-1:0] mant_t;
    typedef logic [RES_W-1:0] res_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // MAC control FSM
    typedef enum logic [1:0] {
        MAC_IDLE = 2'd0,
        MAC_MUL  = 2'd1,
        MAC_ADD  = 2'd2,
        MAC_OUT  = 2'd3
    } mac_state_t;

endpackage

//--- source/mac_if.sv
// MAC operand and result bundle
// host side drives operands and the valid strobe, the core side returns
// the result with its ready pulse and a busy level

`timescale 1ns/10ps

interface mac_if;

    import fp_mac_pkg::*;

    // operands, a is the addend
    mant_t a;
    mant_t b;
    mant_t c;
    logic  valid;

    // result side
    res_t  d;
    logic  ready;
    logic  busy;

    modport host (
        output a, b, c, valid,
        input  d, ready, busy
    );

    modport core (
        input  a, b, c, valid,
        output d, ready, busy
    );

endinterface

//--- source/mul_56.sv
// signed 56x56 mantissa multiplier
// operands are captured on start, the product and its valid bit then
// travel through STAGES register stages, lower 110 bits kept

`timescale 1ns/10ps

module mul_56 #(
    parameter int STAGES = fp_mac_pkg::MUL_STAGES
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  fp_mac_pkg::mant_t a_i,
    input  fp_mac_pkg::mant_t b_i,
    output fp_mac_pkg::res_t  product_o,
    output logic              valid_o
);

    import fp_mac_pkg::*;

    mant_t                      a_q;
    mant_t                      b_q;
    logic [STAGES-1:0]          vld_q;
    logic signed [2*MANT_W-1:0] full_w;
    res_t                       prod_w;

    // first stage, operand capture
    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q <= a_i;
            b_q <= b_i;
        end
    end

    // valid bit follows the data down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int i = 1; i < STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // both operands signed, so the full product is sign extended
    assign full_w = a_q * b_q;
    assign prod_w = full_w[RES_W-1:0];

    generate
        if (STAGES == 1) begin : g_direct
            assign product_o = prod_w;
        end else begin : g_pipe
            res_t pipe_q [STAGES-1];

            // each stage loads only when its valid bit is set
            always_ff @(posedge clk) begin
                if (vld_q[0]) begin
                    pipe_q[0] <= prod_w;
                end
                for (int i = 1; i < STAGES - 1; i++) begin
                    if (vld_q[i]) begin
                        pipe_q[i] <= pipe_q[i-1];
                    end
                end
            end

            assign product_o = pipe_q[STAGES-2];
        end
    endgenerate

    assign valid_o = vld_q[STAGES-1];

    // supported depths
    a_stages_range: assert property (
        @(posedge clk) disable iff (!rst_n) (STAGES >= 1 && STAGES <= 3)
    ) else $error("mul_56 depth %0d outside 1 to 3", STAGES);

endmodule

//--- source/mac_56.sv
// mantissa multiply-accumulate core
// latches the operands, runs the product through mul_56, aligns the addend
// and adds or subtracts the product into the result register

`timescale 1ns/10ps

module mac_56 (
    input  logic clk,
    input  logic rst_n,
    mac_if.core  mac,
    input  logic op_i,
    input  logic acc_en_i,
    input  logic acc_clr_i
);

    import fp_mac_pkg::*;

    mac_state_t state_q;
    mac_state_t state_d;

    mant_t b_q;
    mant_t c_q;
    mant_t addend_q;
    logic  op_q;

    logic  start_q;
    logic  busy_q;
    logic  ready_q;
    res_t  res_q;

    logic  accept_w;
    logic  addend_zero_w;
    logic  mul_valid_w;
    res_t  product_w;
    res_t  term_w;
    res_t  sum_w;

    assign accept_w      = mac.valid && !busy_q;
    assign addend_zero_w = (addend_q == '0);

    // operand capture, in accumulate mode the addend is the top of the last result
    always_ff @(posedge clk) begin
        if (accept_w) begin
            b_q      <= mac.b;
            c_q      <= mac.c;
            addend_q <= acc_en_i ? mant_t'(res_q[RES_W-1 -: MANT_W]) : mac.a;
            op_q     <= op_i;
        end
    end

    mul_56 u_mul_56 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_q),
        .a_i       (b_q),
        .b_i       (c_q),
        .product_o (product_w),
        .valid_o   (mul_valid_w)
    );

    assign term_w = op_q ? -product_w : product_w;
    assign sum_w  = {addend_q, {ALIGN_SHIFT{1'b0}}} + term_w;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            MAC_IDLE: if (accept_w) state_d = MAC_MUL;
            MAC_MUL: begin
                // zero addend goes straight to out
                if (mul_valid_w) begin
                    state_d = addend_zero_w ? MAC_OUT : MAC_ADD;
                end
            end
            MAC_ADD:  state_d = MAC_OUT;
            MAC_OUT:  state_d = MAC_IDLE;
            default:  state_d = MAC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MAC_IDLE;
            start_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // single start pulse in the first mul cycle
            start_q <= accept_w;
            if (accept_w) begin
                busy_q <= 1'b1;
            end else if (state_q == MAC_OUT) begin
                busy_q <= 1'b0;
            end
        end
    end

    // result register doubles as the accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (state_q == MAC_MUL && mul_valid_w && addend_zero_w) begin
                res_q   <= term_w;
                ready_q <= 1'b1;
            end else if (state_q == MAC_ADD) begin
                res_q   <= sum_w;
                ready_q <= 1'b1;
            end else if (acc_clr_i) begin
                res_q <= '0;
            end
        end
    end

    assign mac.d     = res_q;
    assign mac.ready = ready_q;
    assign mac.busy  = busy_q;

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) ready_q |=> !ready_q
    ) else $error("ready held for more than one cycle");

    a_idle_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q == MAC_IDLE) |-> !busy_q
    ) else $error("busy set while the FSM is idle");

endmodule

//--- source/mac_cfg_regs.sv
// MAC configuration and status
// holds the add/subtract and accumulate mode, clears the accumulator on
// each write and counts completed operations

`timescale 1ns/10ps

module mac_cfg_regs (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_we_i,
    input  logic             cfg_op_i,
    input  logic             cfg_acc_i,
    input  logic             done_i,
    output logic             op_o,
    output logic             acc_en_o,
    output logic             acc_clr_o,
    output fp_mac_pkg::cnt_t done_count_o
);

    import fp_mac_pkg::*;

    logic op_q;
    logic acc_q;
    logic clr_q;
    cnt_t cnt_q;

    // mode register, picked up by the MAC at its next accepted operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q  <= 1'b0;
            acc_q <= 1'b0;
            clr_q <= 1'b0;
        end else begin
            if (cfg_we_i) begin
                op_q  <= cfg_op_i;
                acc_q <= cfg_acc_i;
            end
            // clear pulse follows every write
            clr_q <= cfg_we_i;
        end
    end

    // completed operations, wraps at full count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (done_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign op_o         = op_q;
    assign acc_en_o     = acc_q;
    assign acc_clr_o    = clr_q;
    assign done_count_o = cnt_q;

    a_clr_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) acc_clr_o |=> !acc_clr_o
    ) else $error("accumulator clear longer than one cycle");

endmodule

//--- source/fp_mac_top.sv
// fused multiply-add mantissa MAC, top level
// maps the plain ports onto the MAC bundle and wires the configuration
// block alongside the MAC core

`timescale 1ns/10ps

module fp_mac_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  fp_mac_pkg::mant_t a_i,
    input  fp_mac_pkg::mant_t b_i,
    input  fp_mac_pkg::mant_t c_i,
    input  logic              cfg_we_i,
    input  logic              cfg_op_i,
    input  logic              cfg_acc_i,
    output fp_mac_pkg::res_t  d_o,
    output logic              ready_o,
    output logic              busy_o,
    output fp_mac_pkg::cnt_t  done_count_o
);

    logic op;
    logic acc_en;
    logic acc_clr;

    mac_if u_mac_if ();

    // host side of the bundle
    assign u_mac_if.a     = a_i;
    assign u_mac_if.b     = b_i;
    assign u_mac_if.c     = c_i;
    assign u_mac_if.valid = valid_i;

    assign d_o     = u_mac_if.d;
    assign ready_o = u_mac_if.ready;
    assign busy_o  = u_mac_if.busy;

    mac_cfg_regs u_mac_cfg_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we_i     (cfg_we_i),
        .cfg_op_i     (cfg_op_i),
        .cfg_acc_i    (cfg_acc_i),
        .done_i       (u_mac_if.ready),
        .op_o         (op),
        .acc_en_o     (acc_en),
        .acc_clr_o    (acc_clr),
        .done_count_o (done_count_o)
    );

    mac_56 u_mac_56 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac       (u_mac_if.core),
        .op_i      (op),
        .acc_en_i  (acc_en),
        .acc_clr_i (acc_clr)
    );

endmodule

//--- sim/tb_fp_mac.sv
// testbench for the fp_mac mantissa MAC
// random and corner operands in add, subtract, zero addend and accumulate
// modes, results checked by assertions against a model of the MAC rules

`timescale 1ns/10ps

module tb_fp_mac;

    import fp_mac_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  valid_i;
    mant_t a_i;
    mant_t b_i;
    mant_t c_i;
    logic  cfg_we_i;
    logic  cfg_op_i;
    logic  cfg_acc_i;
    res_t  d_o;
    logic  ready_o;
    logic  busy_o;
    cnt_t  done_count_o;

    // model of the mode register, accumulator and counter
    integer seed;
    logic   model_op;
    logic   model_acc_en;
    res_t   model_acc;
    res_t   exp_d;
    logic   pending;
    cnt_t   ready_seen;
    cnt_t   ops_issued;
    mant_t  mant_max;
    mant_t  mant_min;

    fp_mac_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .c_i          (c_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_op_i     (cfg_op_i),
        .cfg_acc_i    (cfg_acc_i),
        .d_o          (d_o),
        .ready_o      (ready_o),
        .busy_o       (busy_o),
        .done_count_o (done_count_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_seen <= '0;
        end else if (ready_o) begin
            ready_seen <= ready_seen + cnt_t'(1);
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic mant_t rand_mant();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[MANT_W-1:0];
    endfunction

    // aligned addend plus or minus the full signed product, wrapped to 110 bits
    function automatic res_t expected_result(input mant_t addend, input mant_t x,
                                             input mant_t y, input logic sub);
        logic signed [2*MANT_W-1:0] prod;
        res_t aligned;
        res_t term;
        prod    = (2*MANT_W)'(x) * (2*MANT_W)'(y);
        aligned = {addend, {ALIGN_SHIFT{1'b0}}};
        term    = prod[RES_W-1:0];
        return sub ? aligned - term : aligned + term;
    endfunction

    task automatic wait_for_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (ready_o !== 1'b1) begin
            if (n >= 40) begin
                stop_with_error("timed out waiting for ready_o after an operation");
            end else begin
                n++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        pending <= 1'b0;
    endtask

    task automatic write_config(input logic op, input logic acc);
        @(posedge clk);
        cfg_we_i  <= 1'b1;
        cfg_op_i  <= op;
        cfg_acc_i <= acc;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        // one more edge so the clear reaches the accumulator
        @(posedge clk);
        model_op     = op;
        model_acc_en = acc;
        model_acc    = '0;
    endtask

    // extra > 0 keeps valid_i high while the MAC is already busy
    task automatic run_op(input mant_t a, input mant_t b, input mant_t c, input int extra);
        mant_t addend;
        res_t  expected;
        addend   = model_acc_en ? mant_t'(model_acc[RES_W-1 -: MANT_W]) : a;
        expected = expected_result(addend, b, c, model_op);
        @(posedge clk);
        valid_i <= 1'b1;
        a_i     <= a;
        b_i     <= b;
        c_i     <= c;
        exp_d   <= expected;
        pending <= 1'b1;
        repeat (extra) begin
            @(posedge clk);
            a_i <= rand_mant();
        end
        @(posedge clk);
        valid_i <= 1'b0;
        model_acc  = expected;
        ops_issued = ops_issued + cnt_t'(1);
        wait_for_ready();
    endtask

    a_result: assert property (
        @(posedge clk) disable iff (!rst_n) ready_o |-> (d_o == exp_d)
    ) else stop_with_error($sformatf("error: %0t: d_o %h, expected %h", $time, d_o, exp_d));

    a_no_extra_ready: assert property (
        @(posedge clk) disable iff (!rst_n) ready_o |-> pending
    ) else stop_with_error("ready_o pulsed with no operation outstanding");

    a_count: assert property (
        @(posedge clk) disable iff (!rst_n) done_count_o == ready_seen
    ) else stop_with_error($sformatf("error: %0t: done_count_o %0d, expected %0d",
                                     $time, done_count_o, ready_seen));

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid_i      = 1'b0;
        a_i          = '0;
        b_i          = '0;
        c_i          = '0;
        cfg_we_i     = 1'b0;
        cfg_op_i     = 1'b0;
        cfg_acc_i    = 1'b0;
        seed         = 32'h2d1f_f696;
        model_op     = 1'b0;
        model_acc_en = 1'b0;
        model_acc    = '0;
        exp_d        = '0;
        pending      = 1'b0;
        ops_issued   = '0;
        mant_max     = {1'b0, {(MANT_W-1){1'b1}}};
        mant_min     = {1'b1, {(MANT_W-1){1'b0}}};

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (ready_o == 1'b0 && busy_o == 1'b0 && done_count_o == '0)
            else stop_with_error($sformatf("error: %0t: after reset ready %b busy %b count %0d",
                                           $time, ready_o, busy_o, done_count_o));

        // add mode
        write_config(1'b0, 1'b0);
        repeat (8) run_op(rand_mant(), rand_mant(), rand_mant(), 0);
        run_op(mant_max, mant_max, mant_min, 0);

        // subtract mode, extreme mantissas included
        write_config(1'b1, 1'b0);
        repeat (8) run_op(rand_mant(), rand_mant(), rand_mant(), 0);
        run_op(mant_max, mant_min, mant_min, 0);
        run_op(mant_min, mant_max, mant_max, 0);
        run_op(mant_min, mant_min, mant_max, 0);
        run_op(mant_max, mant_max, mant_min, 0);

        // zero addend, product alone
        write_config(1'b0, 1'b0);
        run_op('0, rand_mant(), rand_mant(), 0);
        run_op('0, mant_min, mant_max, 0);
        write_config(1'b1, 1'b0);
        run_op('0, rand_mant(), rand_mant(), 0);
        run_op('0, mant_min, mant_min, 0);

        // accumulate, a_i is ignored
        write_config(1'b0, 1'b1);
        repeat (5) run_op(rand_mant(), rand_mant(), rand_mant(), 0);
        write_config(1'b1, 1'b1);
        repeat (4) run_op(rand_mant(), rand_mant(), rand_mant(), 0);

        // valid held while busy
        write_config(1'b0, 1'b0);
        repeat (3) run_op(rand_mant(), rand_mant(), rand_mant(), 3);

        repeat (4) @(posedge clk);
        if (ready_seen == ops_issued && !pending) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_error($sformatf("error: %0t: %0d results seen for %0d operations",
                                      $time, ready_seen, ops_issued));
        end
    end

endmodule

//--- fp_mac.f
source/fp_mac_pkg.sv
source/mac_if.sv
source/mul_56.sv
source/mac_56.sv
source/mac_cfg_regs.sv
source/fp_mac_top.sv
sim/tb_fp_mac.sv

//--- run_sim.sh
#!/bin/sh
# build the fp_mac testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal -f fp_mac.f \
        --top-module tb_fp_mac --Mdir obj_dir -o tb_fp_mac \
    && ./obj_dir/tb_fp_mac > sim.log 2>&1

grep -q "TESTBENCH PASSED" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }
